// File: flist.f
+incdir+test
hdl/routePkg.sv
hdl/nbrTablePkg.sv
hdl/neighborCam.sv
hdl/bestHopTracker.sv
hdl/qtuSequencer.sv
hdl/qtuFmbTop.sv
test/tbQtuFmb.sv

// File: hdl/bestHopTracker.sv
module bestHopTracker (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 stepEn,
    input  logic                 hbReset,
    input  logic                 iAmDestination,
    input  routePkg::hopCount_t  hopsFromCH,
    input  routePkg::hopCount_t  fHopsFromCH,
    input  routePkg::qValue_t    fQValue,
    input  routePkg::nodeId_t    fSourceID,
    input  routePkg::nodeId_t    chosenCH,
    output routePkg::nodeId_t    chosenHop
);
    import routePkg::*;

    // hop count a useful next hop must have
    hopCount_t hopsNeeded;
    // best q seen among candidates at hopsNeeded
    qValue_t   maxQValue;
    logic      candidate;

    // sender sits one hop closer to the cluster head
    assign candidate = (fHopsFromCH == hopsNeeded);

    // tracks our own distance every cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hopsNeeded <= '1;
        end else if (hbReset) begin
            hopsNeeded <= '1;
        end else begin
            hopsNeeded <= hopsFromCH - hopCount_t'(1);
        end
    end

    // next-hop choice
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            maxQValue <= '0;
            chosenHop <= noNode;
        end else if (hbReset) begin
            maxQValue <= '0;
            chosenHop <= noNode;
        end else if (stepEn && iAmDestination) begin
            if (hopsNeeded == '0) begin
                // one hop from the head, go straight there
                chosenHop <= chosenCH;
            end else if (candidate) begin
                if (fQValue > maxQValue) begin
                    maxQValue <= fQValue;
                    chosenHop <= fSourceID;
                end else if ((fQValue == maxQValue) && (fSourceID < chosenHop)) begin
                    // tie on q, lower id wins
                    chosenHop <= fSourceID;
                end
            end
        end
    end

endmodule

// File: hdl/nbrTablePkg.sv
package nbrTablePkg;

    // slot count, fixed by the 5-bit index
    localparam int tableDepth = 32;

    // slot index into the neighbor table
    typedef logic [4:0] nbrIndex_t;

    // filled slots, extra bit so 32 reads as full
    typedef logic [5:0] nbrCount_t;

    // packet sequencer states
    // idle waits for pktValid, process steps the table,
    // output latches the record and returns the credit
    typedef enum logic [1:0] {
        stIdle    = 2'b00,
        stProcess = 2'b01,
        stOutput  = 2'b10
    } qtuState_t;

endpackage

// File: hdl/neighborCam.sv
module neighborCam (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   stepEn,
    input  logic                   hbReset,
    input  routePkg::nodeId_t      fSourceID,
    input  routePkg::nodeId_t      fChosenCH,
    input  routePkg::nodeId_t      chosenCH,
    output nbrTablePkg::nbrIndex_t neighborIndex
);
    import routePkg::*;
    import nbrTablePkg::*;

    // table storage
    logic [tableDepth-1:0] validBits;
    nodeId_t               slotId [tableDepth];
    nbrCount_t             fillCount;

    // match and allocation logic
    logic [tableDepth-1:0] hitVec;
    logic                  anyHit;
    nbrIndex_t             hitIdx;
    logic                  sameCluster;
    logic                  tableFull;
    nbrIndex_t             freeIdx;
    logic                  doAlloc;

    // parallel compare of sender against every live slot
    always_comb begin
        for (int i = 0; i < tableDepth; i++) begin
            hitVec[i] = validBits[i] && (slotId[i] == fSourceID);
        end
    end

    assign anyHit = |hitVec;

    // priority encode, lowest slot wins
    // only one slot can hold a given id, so this is just the one-hot position
    always_comb begin
        hitIdx = '0;
        for (int i = tableDepth - 1; i >= 0; i--) begin
            if (hitVec[i]) begin
                hitIdx = nbrIndex_t'(i);
            end
        end
    end

    // only senders of our own cluster touch the table
    assign sameCluster = (fChosenCH == chosenCH);
    assign tableFull = (fillCount == nbrCount_t'(tableDepth));

    // next free slot is the fill count, slots fill in order
    assign freeIdx = nbrIndex_t'(fillCount);
    assign doAlloc = stepEn && sameCluster && !anyHit && !tableFull;

    // valid bits and fill count
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            validBits <= '0;
            fillCount <= '0;
        end else if (hbReset) begin
            // heartbeat drops every neighbor
            validBits <= '0;
            fillCount <= '0;
        end else if (doAlloc) begin
            validBits[freeIdx] <= 1'b1;
            fillCount <= fillCount + nbrCount_t'(1);
        end
    end

    // id storage, only meaningful where valid is set
    always_ff @(posedge clk) begin
        if (doAlloc) begin
            slotId[freeIdx] <= fSourceID;
        end
    end

    // reported slot for this packet
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            neighborIndex <= '0;
        end else if (stepEn && sameCluster) begin
            if (anyHit) begin
                neighborIndex <= hitIdx;
            end else if (!tableFull) begin
                neighborIndex <= freeIdx;
            end
            // miss on a full table holds the last index
        end
    end

endmodule

// File: hdl/qtuFmbTop.sv
module qtuFmbTop (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   pktValid,
    input  logic                   iAmDestination,
    input  logic                   hbReset,
    input  routePkg::nodeId_t      fSourceID,
    input  routePkg::hopCount_t    fSourceHops,
    input  routePkg::qValue_t      fQValue,
    input  routePkg::energy_t      fEnergyLeft,
    input  routePkg::hopCount_t    fHopsFromCH,
    input  routePkg::nodeId_t      fChosenCH,
    input  routePkg::nodeId_t      chosenCH,
    input  routePkg::hopCount_t    hopsFromCH,
    output routePkg::nodeId_t      nodeId,
    output routePkg::hopCount_t    nodeHops,
    output routePkg::energy_t      nodeEnergy,
    output routePkg::qValue_t      nodeQValue,
    output nbrTablePkg::nbrIndex_t neighborIndex,
    output routePkg::nodeId_t      chosenHop,
    output logic                   creditReturn
);

    // process-state strobe shared by table and tracker
    logic stepEn;

    // packet FSM, record registers, credit return
    qtuSequencer uSeq (
        .clk          (clk),
        .nrst         (nrst),
        .pktValid     (pktValid),
        .fSourceID    (fSourceID),
        .fSourceHops  (fSourceHops),
        .fEnergyLeft  (fEnergyLeft),
        .fQValue      (fQValue),
        .stepEn       (stepEn),
        .nodeId       (nodeId),
        .nodeHops     (nodeHops),
        .nodeEnergy   (nodeEnergy),
        .nodeQValue   (nodeQValue),
        .creditReturn (creditReturn)
    );

    // q-table update side
    neighborCam uCam (
        .clk           (clk),
        .nrst          (nrst),
        .stepEn        (stepEn),
        .hbReset       (hbReset),
        .fSourceID     (fSourceID),
        .fChosenCH     (fChosenCH),
        .chosenCH      (chosenCH),
        .neighborIndex (neighborIndex)
    );

    // find-my-best side
    bestHopTracker uBest (
        .clk            (clk),
        .nrst           (nrst),
        .stepEn         (stepEn),
        .hbReset        (hbReset),
        .iAmDestination (iAmDestination),
        .hopsFromCH     (hopsFromCH),
        .fHopsFromCH    (fHopsFromCH),
        .fQValue        (fQValue),
        .fSourceID      (fSourceID),
        .chosenCH       (chosenCH),
        .chosenHop      (chosenHop)
    );

endmodule

// File: hdl/qtuSequencer.sv
module qtuSequencer (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 pktValid,
    input  routePkg::nodeId_t    fSourceID,
    input  routePkg::hopCount_t  fSourceHops,
    input  routePkg::energy_t    fEnergyLeft,
    input  routePkg::qValue_t    fQValue,
    output logic                 stepEn,
    output routePkg::nodeId_t    nodeId,
    output routePkg::hopCount_t  nodeHops,
    output routePkg::energy_t    nodeEnergy,
    output routePkg::qValue_t    nodeQValue,
    output logic                 creditReturn
);
    import routePkg::*;
    import nbrTablePkg::*;

    qtuState_t state;

    // state register
    // fixed walk idle -> process -> output -> idle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (pktValid) begin
                        state <= stProcess;
                    end
                end
                stProcess: state <= stOutput;
                stOutput:  state <= stIdle;
                default:   state <= stIdle;
            endcase
        end
    end

    // table and tracker advance during process only
    assign stepEn = (state == stProcess);

    // neighbor record for the table writer
    // fields are still held by the source here
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            nodeId     <= '0;
            nodeHops   <= hopCount_t'('1);
            nodeEnergy <= '0;
            nodeQValue <= '0;
        end else if (state == stOutput) begin
            nodeId     <= fSourceID;
            nodeHops   <= fSourceHops;
            nodeEnergy <= fEnergyLeft;
            nodeQValue <= fQValue;
        end
    end

    // one-cycle credit back to the source
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            creditReturn <= 1'b0;
        end else begin
            creditReturn <= (state == stOutput);
        end
    end

endmodule

// File: hdl/routePkg.sv
package routePkg;

    // node identifier as carried in packets and tables
    typedef logic [15:0] nodeId_t;

    // hops to the cluster head
    typedef logic [15:0] hopCount_t;

    // learned link quality, unsigned compare
    typedef logic [15:0] qValue_t;

    // sender's remaining energy
    typedef logic [15:0] energy_t;

    // all-ones id, no node chosen yet
    localparam nodeId_t noNode = '1;

endpackage

// File: run.sh
#!/bin/sh
# build and run the routing core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f flist.f --top-module tbQtuFmb -o simQtuFmb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/simQtuFmb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0

// File: test/qtuModel.svh
`ifndef QTU_MODEL_SVH
`define QTU_MODEL_SVH

// reference copy of the neighbor table and next-hop state
logic [15:0] mIds [32];
int          mCount;
logic [4:0]  mIndex;
logic [15:0] mMaxQ;
logic [15:0] mHop;

// power-on state
task automatic modelReset();
    mCount = 0;
    mIndex = '0;
    mMaxQ = '0;
    mHop = 16'hffff;
endtask

// heartbeat forgets neighbors and next hop, reported index stays
task automatic modelHeartbeat();
    mCount = 0;
    mMaxQ = '0;
    mHop = 16'hffff;
endtask

// one accepted packet against the table and next-hop rules
task automatic modelPacket(input logic [15:0] srcId, input logic [15:0] pktCH,
                           input logic [15:0] ownCH, input logic [15:0] ownHops,
                           input logic [15:0] pktHops, input logic [15:0] q,
                           input logic dest);
    int          found;
    logic [15:0] need;
    found = -1;
    need = ownHops - 16'd1;
    if (pktCH == ownCH) begin
        // search filled slots for a known sender
        for (int i = 0; i < mCount; i++) begin
            if (found < 0 && mIds[i] == srcId) begin
                found = i;
            end
        end
        if (found >= 0) begin
            mIndex = 5'(found);
        end else if (mCount < 32) begin
            mIds[mCount] = srcId;
            mIndex = 5'(mCount);
            mCount++;
        end
    end
    if (dest) begin
        if (need == 16'd0) begin
            mHop = ownCH;
        end else if (pktHops == need) begin
            if (q > mMaxQ) begin
                mMaxQ = q;
                mHop = srcId;
            end else if (q == mMaxQ && srcId < mHop) begin
                mHop = srcId;
            end
        end
    end
endtask

`endif

// File: test/tbQtuFmb.sv
module tbQtuFmb;

    localparam int          seed = 33986;
    localparam int          creditsInit = 1;
    localparam int          numPackets = 300;
    localparam int          timeoutCycles = numPackets * 12 + 200;
    localparam int          poolSize = 40;
    localparam logic [15:0] idBase = 16'h0100;
    localparam logic [15:0] ownCH = 16'h0042;

    logic        clk;
    logic        nrst;
    logic        pktValid;
    logic        iAmDestination;
    logic        hbReset;
    logic [15:0] fSourceID;
    logic [15:0] fSourceHops;
    logic [15:0] fQValue;
    logic [15:0] fEnergyLeft;
    logic [15:0] fHopsFromCH;
    logic [15:0] fChosenCH;
    logic [15:0] chosenCH;
    logic [15:0] hopsFromCH;
    logic [15:0] nodeId;
    logic [15:0] nodeHops;
    logic [15:0] nodeEnergy;
    logic [15:0] nodeQValue;
    logic [4:0]  neighborIndex;
    logic [15:0] chosenHop;
    logic        creditReturn;

    // error tallies, one writer process each
    int valueErrors = 0;
    int protocolErrors = 0;
    int strayReturns = 0;
    // sent by driver, returned seen by monitor
    int sentCount = 0;
    int returnCount = 0;
    int cycleCount = 0;
    int seedVal;

    `include "qtuModel.svh"

    qtuFmbTop dut (
        .clk            (clk),
        .nrst           (nrst),
        .pktValid       (pktValid),
        .iAmDestination (iAmDestination),
        .hbReset        (hbReset),
        .fSourceID      (fSourceID),
        .fSourceHops    (fSourceHops),
        .fQValue        (fQValue),
        .fEnergyLeft    (fEnergyLeft),
        .fHopsFromCH    (fHopsFromCH),
        .fChosenCH      (fChosenCH),
        .chosenCH       (chosenCH),
        .hopsFromCH     (hopsFromCH),
        .nodeId         (nodeId),
        .nodeHops       (nodeHops),
        .nodeEnergy     (nodeEnergy),
        .nodeQValue     (nodeQValue),
        .neighborIndex  (neighborIndex),
        .chosenHop      (chosenHop),
        .creditReturn   (creditReturn)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("** Error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // pulse hbReset while the credit is home, move to a new distance
    task automatic heartbeat(input logic [15:0] newHops);
        @(posedge clk);
        #2;
        hbReset = 1'b1;
        hopsFromCH = newHops;
        @(posedge clk);
        #2;
        hbReset = 1'b0;
        modelHeartbeat();
        @(negedge clk);
        checkValue("chosenHop", 16'hffff, chosenHop);
    endtask

    // one random packet, then wait for its credit and check the results
    task automatic sendPacket(input int pktNum);
        int gap;
        int waitCycles;
        bit seen;
        gap = $urandom % 4;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        #2;
        if (sentCount - returnCount >= creditsInit) begin
            protocolErrors++;
            $display("packet %0d sent while the source held no credit", pktNum);
        end
        fSourceID = idBase + 16'($urandom % poolSize);
        fChosenCH = ($urandom % 4 != 0) ? ownCH : ownCH + 16'h0100;
        fSourceHops = 16'($urandom);
        fEnergyLeft = 16'($urandom);
        // small ranges so q ties and candidates show up often
        fQValue = 16'($urandom % 8);
        fHopsFromCH = 16'(1 + $urandom % 3);
        iAmDestination = 1'($urandom % 2);
        pktValid = 1'b1;
        sentCount++;
        modelPacket(fSourceID, fChosenCH, ownCH, hopsFromCH, fHopsFromCH, fQValue,
                    iAmDestination);
        @(posedge clk);
        #2;
        pktValid = 1'b0;
        // edge N just passed, credit due at the third falling edge
        waitCycles = 0;
        seen = 1'b0;
        while (!seen && waitCycles < 8) begin
            @(negedge clk);
            waitCycles++;
            if (creditReturn) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            protocolErrors++;
            $display("no credit came back for packet %0d", pktNum);
        end else begin
            if (waitCycles != 3) begin
                protocolErrors++;
                $display("credit for packet %0d came back after %0d cycles, not 3",
                         pktNum, waitCycles);
            end
            checkValue("nodeId", fSourceID, nodeId);
            checkValue("nodeHops", fSourceHops, nodeHops);
            checkValue("nodeEnergy", fEnergyLeft, nodeEnergy);
            checkValue("nodeQValue", fQValue, nodeQValue);
            checkValue("neighborIndex", {11'b0, mIndex}, {11'b0, neighborIndex});
            checkValue("chosenHop", mHop, chosenHop);
        end
    endtask

    // every credit return must match a packet in flight
    always @(negedge clk) begin
        if (nrst && creditReturn) begin
            if (returnCount >= sentCount) begin
                strayReturns++;
                $display("credit returned with no packet in flight");
            end else begin
                returnCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutCycles) begin
            $display("run timed out after %0d cycles", cycleCount);
            $display("value errors %0d, protocol errors %0d, stray credits %0d",
                     valueErrors, protocolErrors, strayReturns);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        seedVal = $urandom(seed);
        nrst = 1'b0;
        pktValid = 1'b0;
        iAmDestination = 1'b0;
        hbReset = 1'b0;
        fSourceID = '0;
        fSourceHops = '0;
        fQValue = '0;
        fEnergyLeft = '0;
        fHopsFromCH = '0;
        fChosenCH = '0;
        chosenCH = ownCH;
        // first phase one hop out, head is always the next hop
        hopsFromCH = 16'd1;
        modelReset();
        repeat (16) @(posedge clk);
        #2;
        nrst = 1'b1;
        @(negedge clk);
        if (creditReturn !== 1'b0) begin
            protocolErrors++;
            $display("creditReturn high right after reset");
        end
        checkValue("chosenHop", 16'hffff, chosenHop);
        checkValue("nodeHops", 16'hffff, nodeHops);
        checkValue("nodeId", 16'h0000, nodeId);
        checkValue("nodeEnergy", 16'h0000, nodeEnergy);
        checkValue("nodeQValue", 16'h0000, nodeQValue);
        checkValue("neighborIndex", 16'h0000, {11'b0, neighborIndex});
        for (int p = 0; p < numPackets; p++) begin
            // later phases pick among neighbors by max q
            if (p == numPackets / 3) begin
                heartbeat(16'd3);
            end else if (p == 2 * numPackets / 3) begin
                heartbeat(16'd2);
            end
            sendPacket(p);
        end
        repeat (4) @(posedge clk);
        $display("value errors %0d, protocol errors %0d, stray credits %0d",
                 valueErrors, protocolErrors, strayReturns);
        if (valueErrors == 0 && protocolErrors == 0 && strayReturns == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
